// File: dv/fc_layer_checker.sv
// ======================================================================
// Stream and status protocol assertions, bound to the layer top level
// ======================================================================
`timescale 1ns/100ps

module fc_layer_checker (
    input logic          clk,
    input logic          rst_n,
    input logic          in_ready,
    input logic          busy,
    input logic          done,
    input logic          out_valid,
    input logic          out_ready,
    input fc_pkg::data_t out_data
);

    // Input stream only opens during a run
    in_ready_busy: assert property (@(posedge clk) disable iff (!rst_n)
        in_ready |-> busy)
        else $error("in_ready is high while the engine is not busy");

    // Single-cycle done pulse
    done_single: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done)
        else $error("done stayed high for more than one cycle");

    // Parked output word must not change
    out_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
        else $error("out_valid or out_data changed while the word was stalled");

    // Clean output right after reset release
    out_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !out_valid)
        else $error("out_valid is high in the first cycle after reset");

endmodule

bind fc_layer_top fc_layer_checker chk0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_ready  (in_ready),
    .busy      (busy),
    .done      (done),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data)
);

// File: dv/fc_layer_tb.sv
// ======================================================================
// Testbench for the layer engine. Runs a stimulus table through the
// DUT and checks every output word against a reference model.
// ======================================================================
`timescale 1ns/100ps

module fc_layer_tb;
    import fc_pkg::*;

    localparam int CLK_PERIOD      = 10;
    localparam int RESET_CYCLES    = 2;
    localparam int CYCLES_PER_TEST = 200;
    localparam int IDLE_CYCLES     = 4;

    logic  clk;
    logic  rst_n;
    logic  start;
    logic  use_activation;
    logic  in_valid;
    data_t in_data;
    logic  in_ready;
    logic  out_valid;
    data_t out_data;
    logic  out_ready;
    logic  busy;
    logic  done;

    // Reference copy of weights and biases
    data_t param_w [PARAM_DEPTH];

    // Stimulus table
    // Input word k and expected word k sit at [16*k +: 16]
    string       tab_name    [$];
    logic [63:0] tab_vec     [$];
    bit          tab_mode    [$];
    bit          tab_stall   [$];
    bit          tab_restart [$];
    logic [47:0] tab_exp     [$];

    // Scoreboard state
    data_t got_q [$];
    int    done_cnt;
    int    errors;
    int    failed_tests;
    bit    stall_en;
    logic  ready_pick;

    fc_layer_top dut0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .start          (start),
        .use_activation (use_activation),
        .in_valid       (in_valid),
        .in_data        (in_data),
        .in_ready       (in_ready),
        .out_valid      (out_valid),
        .out_data       (out_data),
        .out_ready      (out_ready),
        .busy           (busy),
        .done           (done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ==================================================================
    // Reference model
    // ==================================================================

    function automatic data_t ref_neuron(input int n, input logic [63:0] vec, input bit relu);
        data_t xw;
        int    acc;
        int    val;
        acc = 0;
        for (int i = 0; i < INPUT_SIZE; i++) begin
            xw  = vec[16*i +: 16];
            acc = acc + int'(xw) * int'(param_w[n*INPUT_SIZE + i]);
        end
        // Back to Q4.12 and add the bias
        val = (acc >>> FRAC_BITS) + int'(param_w[WEIGHT_COUNT + n]);
        if (relu && val < 0) begin
            val = 0;
        end
        if (val > int'(SAT_POS)) begin
            val = int'(SAT_POS);
        end else if (val < int'(SAT_NEG)) begin
            val = int'(SAT_NEG);
        end
        return val[DATA_W-1:0];
    endfunction

    task automatic add_test(input string name, input data_t x0, x1, x2, x3,
                            input bit mode, input bit stall, input bit restart);
        logic [63:0] vec;
        logic [47:0] exp_w;
        vec = {x3, x2, x1, x0};
        for (int n = 0; n < OUTPUT_SIZE; n++) begin
            exp_w[16*n +: 16] = ref_neuron(n, vec, mode);
        end
        tab_name.push_back(name);
        tab_vec.push_back(vec);
        tab_mode.push_back(mode);
        tab_stall.push_back(stall);
        tab_restart.push_back(restart);
        tab_exp.push_back(exp_w);
    endtask

    // Name, x0..x3, relu mode, random out_ready, second start while busy
    task automatic build_table();
        add_test("bypass_small", 16'h0800, 16'h0400, 16'hFC00, 16'h1000, 0, 0, 0);
        add_test("bypass_mixed", 16'hF000, 16'h0800, 16'h0C00, 16'hF800, 0, 0, 0);
        add_test("sat_high",     16'h3000, 16'h3000, 16'h3000, 16'h3000, 0, 0, 0);
        add_test("sat_low",      16'hD000, 16'hD000, 16'hD000, 16'hD000, 0, 0, 0);
        add_test("relu_high",    16'h3000, 16'h3000, 16'h3000, 16'h3000, 1, 0, 0);
        add_test("relu_small",   16'h0800, 16'h0400, 16'hFC00, 16'h1000, 1, 0, 0);
        add_test("relu_low",     16'hD000, 16'hD000, 16'hD000, 16'hD000, 1, 0, 0);
        add_test("bp_mixed",     16'hF000, 16'h0800, 16'h0C00, 16'hF800, 0, 1, 0);
        add_test("bp_relu",      16'h2000, 16'hE000, 16'h1800, 16'h0200, 1, 1, 0);
        add_test("restart_busy", 16'h3000, 16'h3000, 16'h3000, 16'h3000, 0, 1, 1);
        add_test("rand_a", 16'($urandom), 16'($urandom), 16'($urandom), 16'($urandom),
                 1'($urandom), 1, 0);
        add_test("rand_b", 16'($urandom), 16'($urandom), 16'($urandom), 16'($urandom),
                 1'($urandom), 1, 1);
    endtask

    // ==================================================================
    // Output side
    // ==================================================================

    // Draw out_ready mid-cycle and drive it on the next rising edge
    always @(negedge clk) begin
        if (stall_en) begin
            ready_pick <= ($urandom % 3) != 0;
        end else begin
            ready_pick <= 1'b1;
        end
    end

    always @(posedge clk) begin
        out_ready <= ready_pick;
    end

    // Collect accepted words and watch done
    always @(negedge clk) begin
        if (rst_n) begin
            if (out_valid && out_ready) begin
                got_q.push_back(out_data);
            end
            if (done) begin
                done_cnt++;
                assert (got_q.size() == OUTPUT_SIZE && !busy) else begin
                    $display("done came after %0d accepted words or with busy high",
                             got_q.size());
                    errors++;
                end
            end
        end
    end

    // ==================================================================
    // Test sequence
    // ==================================================================

    task automatic run_test(input int t);
        int          k;
        int          err_before;
        data_t       exp_word;
        logic [63:0] vec;
        err_before = errors;
        vec        = tab_vec[t];
        got_q.delete();
        done_cnt = 0;
        stall_en       <= tab_stall[t];
        start          <= 1'b1;
        use_activation <= tab_mode[t];
        @(posedge clk);
        start <= 1'b0;
        // Vector with random gaps on in_valid
        k = 0;
        while (k < INPUT_SIZE) begin
            in_valid <= ($urandom % 4) != 0;
            in_data  <= vec[16*k +: 16];
            @(posedge clk);
            if (in_valid && in_ready) begin
                k++;
            end
        end
        in_valid <= 1'b0;
        // Second start in the other mode must be ignored
        if (tab_restart[t]) begin
            start          <= 1'b1;
            use_activation <= !tab_mode[t];
            @(posedge clk);
            start          <= 1'b0;
            use_activation <= tab_mode[t];
        end
        while (done_cnt == 0) begin
            @(posedge clk);
        end
        // Quiet window catches stray words or pulses
        repeat (IDLE_CYCLES) @(posedge clk);
        assert (got_q.size() == OUTPUT_SIZE) else begin
            $display("Fail %s: word count expected %0d actual %0d",
                     tab_name[t], OUTPUT_SIZE, got_q.size());
            errors++;
        end
        for (int n = 0; n < OUTPUT_SIZE && n < got_q.size(); n++) begin
            exp_word = tab_exp[t][16*n +: 16];
            assert (got_q[n] == exp_word) else begin
                $display("Fail %s: neuron %0d expected %h actual %h",
                         tab_name[t], n, exp_word, got_q[n]);
                errors++;
            end
        end
        assert (done_cnt == 1 && !busy) else begin
            $display("Test %s: done pulsed %0d times or busy stayed high",
                     tab_name[t], done_cnt);
            errors++;
        end
        if (errors == err_before) begin
            $display("Test %-14s ok", tab_name[t]);
        end else begin
            $display("Test %-14s FAILED with %0d errors", tab_name[t], errors - err_before);
            failed_tests++;
        end
    endtask

    initial begin
        void'($urandom(32'hc1d5));
        rst_n          = 1'b0;
        start          = 1'b0;
        use_activation = 1'b0;
        in_valid       = 1'b0;
        in_data        = '0;
        out_ready      = 1'b0;
        stall_en       = 1'b0;
        ready_pick     = 1'b1;
        done_cnt       = 0;
        errors         = 0;
        failed_tests   = 0;
        $readmemh("fc_params.hex", param_w);
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        for (int t = 0; t < tab_name.size(); t++) begin
            run_test(t);
        end
        $display("Tests run %0d, tests failed %0d, errors %0d",
                 tab_name.size(), failed_tests, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // Watchdog bound scales with the table length
    initial begin
        #(CLK_PERIOD * RESET_CYCLES);
        #(CLK_PERIOD * CYCLES_PER_TEST * tab_name.size());
        $display("Watchdog timeout, the run did not finish in time");
        $display("Verification failed");
        $finish;
    end

endmodule

// File: fc_params.hex
// One Q4.12 word per line: weights W[n][i] neuron-major, then biases B[0..2]
0800
1000
F000
0400
2000
2000
2000
2000
E000
1000
F800
0C00
0100
FF00
0200

// File: flist.f
src/fc_pkg.sv
src/fc_input_buffer.sv
src/fc_param_rom.sv
src/fc_sequencer.sv
src/fc_neuron_core.sv
src/fc_layer_top.sv
dv/fc_layer_checker.sv
dv/fc_layer_tb.sv

// File: src/fc_input_buffer.sv
// ======================================================================
// Input vector buffer. Takes one vector from the input stream while
// load_en is high, then serves stored elements by index.
// ======================================================================
`timescale 1ns/100ps

module fc_input_buffer (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        load_en,
    input  logic                        in_valid,
    input  fc_pkg::data_t               in_data,
    input  logic [fc_pkg::IN_IDX_W-1:0] rd_idx,
    output logic                        in_ready,
    output logic                        loaded,
    output fc_pkg::data_t               in_elem
);
    import fc_pkg::*;

    // One extra bit so the count can reach INPUT_SIZE
    logic [IN_IDX_W:0] wr_cnt;
    data_t             vec_mem [INPUT_SIZE];

    // Open while loading and not yet full
    assign in_ready = load_en && (wr_cnt < INPUT_SIZE);
    assign loaded   = (wr_cnt == INPUT_SIZE);

    // Word counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_cnt <= '0;
        end else if (!load_en) begin
            // Ready for the next run
            wr_cnt <= '0;
        end else if (in_valid && in_ready) begin
            wr_cnt <= wr_cnt + 1'b1;
        end
    end

    // Vector storage
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            vec_mem[wr_cnt[IN_IDX_W-1:0]] <= in_data;
        end
    end

    // Registered read, one cycle after the index
    always_ff @(posedge clk) begin
        in_elem <= vec_mem[rd_idx];
    end

endmodule

// File: src/fc_layer_top.sv
// ======================================================================
// Fully connected layer engine, 4 inputs by 3 neurons, Q4.12.
// Input and output are valid/ready streams, one run per start.
// ======================================================================
`timescale 1ns/100ps

module fc_layer_top (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          start,
    input  logic          use_activation,
    input  logic          in_valid,
    input  fc_pkg::data_t in_data,
    output logic          in_ready,
    output logic          out_valid,
    output fc_pkg::data_t out_data,
    input  logic          out_ready,
    output logic          busy,
    output logic          done
);
    import fc_pkg::*;

    // Load handshake
    logic load_en;
    logic loaded;

    // Term stream from the sequencer
    logic                    term_valid;
    logic                    term_first;
    logic                    term_last;
    logic [IN_IDX_W-1:0]     term_idx;
    logic [PARAM_ADDR_W-1:0] weight_addr;
    logic [NEURON_IDX_W-1:0] neuron_idx;

    // Registered operands into the core
    data_t in_elem;
    data_t weight;
    data_t bias;
    logic  result_hold;

    fc_input_buffer u_input_buffer (
        .clk      (clk),
        .rst_n    (rst_n),
        .load_en  (load_en),
        .in_valid (in_valid),
        .in_data  (in_data),
        .rd_idx   (term_idx),
        .in_ready (in_ready),
        .loaded   (loaded),
        .in_elem  (in_elem)
    );

    fc_param_rom u_param_rom (
        .clk         (clk),
        .weight_addr (weight_addr),
        .neuron_idx  (neuron_idx),
        .weight      (weight),
        .bias        (bias)
    );

    fc_sequencer u_sequencer (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .loaded      (loaded),
        .result_hold (result_hold),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .load_en     (load_en),
        .busy        (busy),
        .done        (done),
        .term_valid  (term_valid),
        .term_first  (term_first),
        .term_last   (term_last),
        .term_idx    (term_idx),
        .weight_addr (weight_addr),
        .neuron_idx  (neuron_idx)
    );

    fc_neuron_core u_neuron_core (
        .clk            (clk),
        .rst_n          (rst_n),
        .start          (start),
        .use_activation (use_activation),
        .term_valid     (term_valid),
        .term_first     (term_first),
        .term_last      (term_last),
        .in_elem        (in_elem),
        .weight         (weight),
        .bias           (bias),
        .out_ready      (out_ready),
        .out_valid      (out_valid),
        .out_data       (out_data),
        .result_hold    (result_hold)
    );

endmodule

// File: src/fc_neuron_core.sv
// ======================================================================
// Neuron datapath. Multiplies aligned input and weight, accumulates,
// scales, adds bias, applies clamp or ReLU and holds the output word.
// ======================================================================
`timescale 1ns/100ps

module fc_neuron_core (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          start,
    input  logic          use_activation,
    input  logic          term_valid,
    input  logic          term_first,
    input  logic          term_last,
    input  fc_pkg::data_t in_elem,
    input  fc_pkg::data_t weight,
    input  fc_pkg::data_t bias,
    input  logic          out_ready,
    output logic          out_valid,
    output fc_pkg::data_t out_data,
    output logic          result_hold
);
    import fc_pkg::*;

    // Run tracking and mode
    logic                    run_on;
    logic                    run_end;
    logic                    relu_on;
    logic [NEURON_IDX_W-1:0] word_cnt;

    // Term flags, d1 aligns with memory data, d2 with the product
    logic v_d1, f_d1, l_d1;
    logic v_d2, f_d2, l_d2;

    acc_t  prod_q;
    acc_t  acc_q;
    acc_t  acc_next;
    acc_t  biased;
    data_t bias_q;
    data_t shaped;

    logic word_taken;
    logic result_load;

    assign word_taken  = out_valid && out_ready;
    assign result_load = v_d2 && l_d2;
    assign result_hold = out_valid && !out_ready;

    // ==================================================================
    // Mode capture
    // ==================================================================

    // Mode follows only a start the sequencer accepts; run_end
    // covers the finish cycle after the last word
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_on   <= 1'b0;
            run_end  <= 1'b0;
            relu_on  <= 1'b0;
            word_cnt <= '0;
        end else begin
            run_end <= 1'b0;
            if (word_taken) begin
                if (word_cnt == NEURON_IDX_W'(OUTPUT_SIZE - 1)) begin
                    word_cnt <= '0;
                    run_end  <= 1'b1;
                end else begin
                    word_cnt <= word_cnt + 1'b1;
                end
            end
            if (run_end) begin
                run_on <= 1'b0;
            end else if (start && !run_on) begin
                run_on  <= 1'b1;
                relu_on <= use_activation;
            end
        end
    end

    // ==================================================================
    // Term alignment
    // ==================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            {v_d1, f_d1, l_d1} <= '0;
            {v_d2, f_d2, l_d2} <= '0;
        end else begin
            {v_d1, f_d1, l_d1} <= {term_valid, term_first, term_last};
            {v_d2, f_d2, l_d2} <= {v_d1, f_d1, l_d1};
        end
    end

    // ==================================================================
    // Multiply, accumulate, bias
    // ==================================================================

    // Bias port moves on to the next neuron early, so latch it here
    always_ff @(posedge clk) begin
        prod_q <= in_elem * weight;
        if (v_d1 && l_d1) begin
            bias_q <= bias;
        end
        if (v_d2) begin
            acc_q <= acc_next;
        end
    end

    // First term restarts the sum
    assign acc_next = f_d2 ? prod_q : acc_q + prod_q;
    // Back to Q4.12 scale before the bias
    assign biased   = (acc_next >>> FRAC_BITS) + acc_t'(bias_q);

    // ReLU first, then clamp to +-7.0
    always_comb begin
        if (relu_on && biased < 0) begin
            shaped = '0;
        end else if (biased > acc_t'(SAT_POS)) begin
            shaped = SAT_POS;
        end else if (biased < acc_t'(SAT_NEG)) begin
            shaped = SAT_NEG;
        end else begin
            shaped = biased[DATA_W-1:0];
        end
    end

    // ==================================================================
    // Output register
    // ==================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (result_load) begin
            out_valid <= 1'b1;
        end else if (word_taken) begin
            out_valid <= 1'b0;
        end
    end

    // Never loads while a word waits, sequencer stall guarantees it
    always_ff @(posedge clk) begin
        if (result_load) begin
            out_data <= shaped;
        end
    end

endmodule

// File: src/fc_param_rom.sv
// ======================================================================
// Weight and bias memory, filled from the data file at elaboration.
// Two registered read ports: weights by address, biases by neuron.
// ======================================================================
`timescale 1ns/100ps

module fc_param_rom (
    input  logic                            clk,
    input  logic [fc_pkg::PARAM_ADDR_W-1:0] weight_addr,
    input  logic [fc_pkg::NEURON_IDX_W-1:0] neuron_idx,
    output fc_pkg::data_t                   weight,
    output fc_pkg::data_t                   bias
);
    import fc_pkg::*;

    data_t                   param_mem [PARAM_DEPTH];
    logic [PARAM_ADDR_W-1:0] bias_addr;

    // ==================================================================
    // Contents
    // ==================================================================

    // Layout: W[n][i] at n*INPUT_SIZE+i, then B[n]
    initial begin
        $readmemh(PARAM_FILE, param_mem);
    end

    // ==================================================================
    // Read ports
    // ==================================================================

    // Biases sit right after the last weight
    assign bias_addr = PARAM_ADDR_W'(WEIGHT_COUNT) + PARAM_ADDR_W'(neuron_idx);

    // Weight port
    always_ff @(posedge clk) begin
        weight <= param_mem[weight_addr];
    end

    // Bias port
    always_ff @(posedge clk) begin
        bias <= param_mem[bias_addr];
    end

endmodule

// File: src/fc_pkg.sv
// ======================================================================
// Shared sizes, Q4.12 fixed-point widths and clamp limits for the
// fully connected layer engine. Imported by every RTL unit.
// ======================================================================
package fc_pkg;

    // Fixed-point format, Q4.12
    localparam int DATA_W    = 16;
    localparam int FRAC_BITS = 12;

    // Layer shape
    localparam int INPUT_SIZE  = 4;
    localparam int OUTPUT_SIZE = 3;

    // Index widths
    localparam int IN_IDX_W     = 2;
    localparam int NEURON_IDX_W = 2;

    // Parameter memory layout
    // Weights neuron-major first, then one bias per neuron
    localparam int WEIGHT_COUNT = INPUT_SIZE * OUTPUT_SIZE;
    localparam int PARAM_DEPTH  = WEIGHT_COUNT + OUTPUT_SIZE;
    localparam int PARAM_ADDR_W = 4;

    // Data words
    typedef logic signed [DATA_W-1:0]   data_t;
    // Full product and running sum
    typedef logic signed [2*DATA_W-1:0] acc_t;

    // Clamp limits, +7.0 and -7.0
    localparam data_t SAT_POS = 16'sh7000;
    localparam data_t SAT_NEG = 16'sh9000;

    // Weight and bias image, one hex word per line
    localparam string PARAM_FILE = "fc_params.hex";

endpackage

// File: src/fc_sequencer.sv
// ======================================================================
// Layer control FSM. Loads the input vector, then issues one term per
// cycle in neuron-major order and counts output words to end the run.
// ======================================================================
`timescale 1ns/100ps

module fc_sequencer (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            start,
    input  logic                            loaded,
    input  logic                            result_hold,
    input  logic                            out_valid,
    input  logic                            out_ready,
    output logic                            load_en,
    output logic                            busy,
    output logic                            done,
    output logic                            term_valid,
    output logic                            term_first,
    output logic                            term_last,
    output logic [fc_pkg::IN_IDX_W-1:0]     term_idx,
    output logic [fc_pkg::PARAM_ADDR_W-1:0] weight_addr,
    output logic [fc_pkg::NEURON_IDX_W-1:0] neuron_idx
);
    import fc_pkg::*;

    // State encoding
    localparam logic [2:0] ST_IDLE   = 3'd0;
    localparam logic [2:0] ST_LOAD   = 3'd1;
    localparam logic [2:0] ST_ISSUE  = 3'd2;
    localparam logic [2:0] ST_DRAIN  = 3'd3;
    localparam logic [2:0] ST_FINISH = 3'd4;

    logic [2:0]              state;
    logic [NEURON_IDX_W-1:0] out_cnt;
    logic                    at_last;
    logic                    word_taken;

    // ==================================================================
    // Term stream and status
    // ==================================================================

    assign at_last    = (term_idx == IN_IDX_W'(INPUT_SIZE - 1));
    assign word_taken = out_valid && out_ready;

    // Hold the last term while a finished result still waits,
    // so at most one result is ever parked in the core
    assign term_valid = (state == ST_ISSUE) && !(at_last && result_hold);
    assign term_first = (term_idx == '0);
    assign term_last  = at_last;

    assign load_en = (state == ST_LOAD);
    assign busy    = (state == ST_LOAD) || (state == ST_ISSUE) || (state == ST_DRAIN);
    // One-cycle pulse, busy already low here
    assign done    = (state == ST_FINISH);

    // ==================================================================
    // State and index registers
    // ==================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= ST_IDLE;
            term_idx    <= '0;
            weight_addr <= '0;
            neuron_idx  <= '0;
            out_cnt     <= '0;
        end else begin
            // Output words can be taken while later terms issue
            if (word_taken) begin
                out_cnt <= out_cnt + 1'b1;
            end

            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state       <= ST_LOAD;
                        term_idx    <= '0;
                        weight_addr <= '0;
                        neuron_idx  <= '0;
                        out_cnt     <= '0;
                    end
                end

                ST_LOAD: begin
                    if (loaded) begin
                        state <= ST_ISSUE;
                    end
                end

                ST_ISSUE: begin
                    if (term_valid) begin
                        // Weights are contiguous in neuron-major order
                        weight_addr <= weight_addr + 1'b1;
                        if (at_last) begin
                            term_idx <= '0;
                            if (neuron_idx == NEURON_IDX_W'(OUTPUT_SIZE - 1)) begin
                                state <= ST_DRAIN;
                            end else begin
                                neuron_idx <= neuron_idx + 1'b1;
                            end
                        end else begin
                            term_idx <= term_idx + 1'b1;
                        end
                    end
                end

                ST_DRAIN: begin
                    // Wait for the final word to leave
                    if (word_taken && (out_cnt == NEURON_IDX_W'(OUTPUT_SIZE - 1))) begin
                        state <= ST_FINISH;
                    end
                end

                ST_FINISH: begin
                    state <= ST_IDLE;
                end

                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule
